/* rtl/fb_geom_pkg.sv */
package fb_geom_pkg;

	// 3-bit colour depth
	localparam int COLOR_W = 3;

	// coordinate widths allow frames up to 1024 x 512
	localparam int X_W = 10;
	localparam int Y_W = 9;

	// one pixel colour
	typedef logic [COLOR_W-1:0] color_t;

	// column index within a line
	typedef logic [X_W-1:0] coord_x_t;

	// line index within a frame
	typedef logic [Y_W-1:0] coord_y_t;

	// pixel location that also addresses the frame cell on both ports
	// x sits in the upper bits, y in the lower
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
	} pixel_pos_t;

endpackage

/* rtl/fb_stream_pkg.sv */
package fb_stream_pkg;

	// stream words are built from the geometry types
	import fb_geom_pkg::*;

	// rasterizer input word
	// location and colour of one drawn pixel in 22 bits
	typedef struct packed {
		pixel_pos_t pos;
		color_t     color;
	} rast_pixel_t;

	// 5-bit display output word
	// sof marks pixel (0,0) of a frame
	// eol marks the last column of a line
	typedef struct packed {
		color_t color;
		logic   sof;
		logic   eol;
	} disp_beat_t;

endpackage

/* rtl/frame_cell.sv */
`timescale 1ns/1ps
module frame_cell
	import fb_geom_pkg::*;
#(
	parameter int FRAME_W = 640,
	parameter int FRAME_H = 480
) (
	input  logic       clk,
	input  logic       wr_en,
	input  pixel_pos_t wr_pos,
	input  color_t     wr_color,
	input  logic       rd_en,
	input  pixel_pos_t rd_pos,
	output color_t     rd_color
);

	// one colour per pixel in row-major order
	localparam int DEPTH  = FRAME_W * FRAME_H;
	localparam int ADDR_W = $clog2(DEPTH);

	color_t mem [DEPTH];

	// linear address is row * FRAME_W + column
	function automatic logic [ADDR_W-1:0] cell_addr(input pixel_pos_t pos);
		int unsigned lin;
		lin = int'(pos.y) * FRAME_W + int'(pos.x);
		return lin[ADDR_W-1:0];
	endfunction

	// the writer enables this port for in-range pixels only
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[cell_addr(wr_pos)] <= wr_color;
		end
	end

	// registered read
	// data holds while rd_en is low so a stalled beat stays stable
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_color <= mem[cell_addr(rd_pos)];
		end
	end

endmodule

/* rtl/pixel_writer.sv */
`timescale 1ns/1ps
module pixel_writer
	import fb_geom_pkg::*, fb_stream_pkg::*;
#(
	parameter int FRAME_W = 640,
	parameter int FRAME_H = 480
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  rast_pixel_t in_pixel,
	output logic        in_ready,
	input  logic        write_hold,
	input  logic        back_sel,
	output logic        wr_en0,
	output logic        wr_en1,
	output pixel_pos_t  wr_pos,
	output color_t      wr_color
);

	// limits one bit wider than the coordinates so a full 1024 x 512 frame fits
	localparam logic [X_W:0] X_LIM = (X_W + 1)'(FRAME_W);
	localparam logic [Y_W:0] Y_LIM = (Y_W + 1)'(FRAME_H);

	logic        accept;
	logic        pend_q;
	logic        sel_q;
	rast_pixel_t pix_q;
	logic        in_range;

	// ready follows hold only and never in_valid
	assign in_ready = ~write_hold;
	assign accept   = in_valid & in_ready;

	// a pixel occupies the write stage for one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			pend_q <= 1'b0;
		end else begin
			pend_q <= accept;
		end
	end

	// capture the pixel and the back bank it was accepted for
	always_ff @(posedge clk) begin
		if (accept) begin
			pix_q <= in_pixel;
			sel_q <= back_sel;
		end
	end

	// out-of-frame pixels were taken but are dropped here
	assign in_range = ({1'b0, pix_q.pos.x} < X_LIM) && ({1'b0, pix_q.pos.y} < Y_LIM);

	// steer the write to the back bank
	assign wr_en0   = pend_q & in_range & ~sel_q;
	assign wr_en1   = pend_q & in_range & sel_q;
	assign wr_pos   = pix_q.pos;
	assign wr_color = pix_q.color;

endmodule

/* rtl/scan_reader.sv */
`timescale 1ns/1ps
module scan_reader
	import fb_geom_pkg::*, fb_stream_pkg::*;
#(
	parameter int FRAME_W = 640,
	parameter int FRAME_H = 480,
	parameter int CREDITS = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       credit_return,
	input  logic       back_sel,
	output logic       rd_en,
	output pixel_pos_t rd_pos,
	input  color_t     rd_color0,
	input  color_t     rd_color1,
	output logic       frame_last_issue,
	output logic       out_valid,
	output disp_beat_t out_beat
);

	// counter must hold 0 .. CREDITS inclusive
	localparam int               CNT_W      = $clog2(CREDITS + 1);
	localparam logic [CNT_W-1:0] CREDIT_MAX = CNT_W'(CREDITS);
	localparam coord_x_t         X_LAST     = coord_x_t'(FRAME_W - 1);
	localparam coord_y_t         Y_LAST     = coord_y_t'(FRAME_H - 1);

	logic [CNT_W-1:0] credit_q;
	pixel_pos_t       pos_q;
	logic             last_col;
	logic             last_row;
	logic             vld_q;
	logic             sof_q;
	logic             eol_q;
	logic             front_q;

	// issue whenever the downstream FIFO has room
	assign rd_en  = (credit_q != '0);
	assign rd_pos = pos_q;

	assign last_col = (pos_q.x == X_LAST);
	assign last_row = (pos_q.y == Y_LAST);

	// tells the controller a frame boundary has just been crossed
	assign frame_last_issue = rd_en & last_col & last_row;

	// credit is spent at issue and the beat follows one cycle later
	// a return and an issue in the same cycle cancel out
	always_ff @(posedge clk) begin
		if (rst) begin
			credit_q <= CREDIT_MAX;
		end else begin
			case ({credit_return, rd_en})
				2'b10:   credit_q <= credit_q + CNT_W'(1);
				2'b01:   credit_q <= credit_q - CNT_W'(1);
				default: credit_q <= credit_q;
			endcase
		end
	end

	// raster scan position that holds while out of credit
	always_ff @(posedge clk) begin
		if (rst) begin
			pos_q <= '0;
		end else if (rd_en) begin
			if (last_col) begin
				pos_q.x <= '0;
				pos_q.y <= last_row ? '0 : pos_q.y + coord_y_t'(1);
			end else begin
				pos_q.x <= pos_q.x + coord_x_t'(1);
			end
		end
	end

	// valid for the beat stage
	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q <= 1'b0;
		end else begin
			vld_q <= rd_en;
		end
	end

	// markers and bank choice ride along with the registered read
	// front bank is taken at issue so a swap never splits a beat
	always_ff @(posedge clk) begin
		if (rd_en) begin
			sof_q   <= (pos_q.x == '0) && (pos_q.y == '0);
			eol_q   <= last_col;
			front_q <= ~back_sel;
		end
	end

	assign out_valid = vld_q;

	always_comb begin
		out_beat.color = front_q ? rd_color1 : rd_color0;
		out_beat.sof   = sof_q;
		out_beat.eol   = eol_q;
	end

endmodule

/* rtl/frame_buffer_ctrl.sv */
`timescale 1ns/1ps
module frame_buffer_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic frame_commit,
	input  logic frame_last_issue,
	output logic back_sel,
	output logic write_hold
);

	// bank role where 0 means bank 0 is drawn into and bank 1 is shown
	logic back_sel_q;

	// a finished back bank is waiting for the end of the display frame
	logic pending_q;

	// swap when the last read of a frame goes out while a commit waits
	logic swap;

	assign swap = pending_q & frame_last_issue;

	// commit tracking
	// set by the commit pulse and cleared by the swap
	// the rasterizer must not commit again before the swap, so a commit
	// landing on the swap cycle is not expected
	always_ff @(posedge clk) begin
		if (rst) begin
			pending_q <= 1'b0;
		end else if (swap) begin
			pending_q <= 1'b0;
		end else if (frame_commit) begin
			pending_q <= 1'b1;
		end
	end

	// role register
	// flips only at a frame boundary so the display never mixes two images
	// the next issued read already uses the new front bank
	always_ff @(posedge clk) begin
		if (rst) begin
			back_sel_q <= 1'b0;
		end else if (swap) begin
			back_sel_q <= ~back_sel_q;
		end
	end

	assign back_sel = back_sel_q;

	// writer is held from the cycle after the commit until the swap
	// hold drops in the same cycle the roles change
	assign write_hold = pending_q;

endmodule

/* rtl/frame_buffer_top.sv */
`timescale 1ns/1ps
module frame_buffer_top
	import fb_geom_pkg::*, fb_stream_pkg::*;
#(
	parameter int FRAME_W = 640,
	parameter int FRAME_H = 480,
	parameter int CREDITS = 16
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  rast_pixel_t in_pixel,
	output logic        in_ready,
	input  logic        frame_commit,
	output logic        out_valid,
	output disp_beat_t  out_beat,
	input  logic        credit_return
);

	// bank roles and swap handshake
	logic back_sel;
	logic write_hold;
	logic frame_last_issue;

	// write side shared by both banks except the enables
	logic       wr_en0;
	logic       wr_en1;
	pixel_pos_t wr_pos;
	color_t     wr_color;

	// read side with one scan address for both banks
	logic       rd_en;
	pixel_pos_t rd_pos;
	color_t     rd_color0;
	color_t     rd_color1;

	frame_buffer_ctrl ctrl_i (
		.clk              (clk),
		.rst              (rst),
		.frame_commit     (frame_commit),
		.frame_last_issue (frame_last_issue),
		.back_sel         (back_sel),
		.write_hold       (write_hold)
	);

	pixel_writer #(
		.FRAME_W (FRAME_W),
		.FRAME_H (FRAME_H)
	) writer_i (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_pixel   (in_pixel),
		.in_ready   (in_ready),
		.write_hold (write_hold),
		.back_sel   (back_sel),
		.wr_en0     (wr_en0),
		.wr_en1     (wr_en1),
		.wr_pos     (wr_pos),
		.wr_color   (wr_color)
	);

	scan_reader #(
		.FRAME_W (FRAME_W),
		.FRAME_H (FRAME_H),
		.CREDITS (CREDITS)
	) reader_i (
		.clk              (clk),
		.rst              (rst),
		.credit_return    (credit_return),
		.back_sel         (back_sel),
		.rd_en            (rd_en),
		.rd_pos           (rd_pos),
		.rd_color0        (rd_color0),
		.rd_color1        (rd_color1),
		.frame_last_issue (frame_last_issue),
		.out_valid        (out_valid),
		.out_beat         (out_beat)
	);

	// bank 0 is the back bank after reset
	frame_cell #(
		.FRAME_W (FRAME_W),
		.FRAME_H (FRAME_H)
	) bank0_i (
		.clk      (clk),
		.wr_en    (wr_en0),
		.wr_pos   (wr_pos),
		.wr_color (wr_color),
		.rd_en    (rd_en),
		.rd_pos   (rd_pos),
		.rd_color (rd_color0)
	);

	// bank 1 is the front bank after reset
	frame_cell #(
		.FRAME_W (FRAME_W),
		.FRAME_H (FRAME_H)
	) bank1_i (
		.clk      (clk),
		.wr_en    (wr_en1),
		.wr_pos   (wr_pos),
		.wr_color (wr_color),
		.rd_en    (rd_en),
		.rd_pos   (rd_pos),
		.rd_color (rd_color1)
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
module tb_clock_gen #(
	parameter int HALF_PERIOD = 4,
	parameter int RST_CYCLES  = 5
) (
	output logic clk,
	output logic rst
);

	// free-running clock with an 8 ns period
	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// reset held over the first rising edges and released on an edge
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* tb/frame_buffer_tb.sv */
`timescale 1ns/1ps
module frame_buffer_tb
	import fb_geom_pkg::*, fb_stream_pkg::*;
();

	localparam int FW         = 8;
	localparam int FH         = 4;
	localparam int CR         = 4;
	localparam int NPIX       = FW * FH;
	localparam int NROWS      = 5;
	localparam int WAIT_LIMIT = 4000;
	localparam int STALL_LEN  = 40;
	localparam logic [1:0] ORD_FWD = 2'd0;
	localparam logic [1:0] ORD_REV = 2'd1;
	localparam logic [1:0] ORD_MIX = 2'd2;

	// one stimulus row with image seed, write order, credit delay and long credit stall
	typedef struct packed {
		logic [2:0] seed;
		logic [1:0] order;
		logic [1:0] delay;
		logic       stall;
	} row_t;

	logic        clk;
	logic        rst;
	logic        in_valid;
	rast_pixel_t in_pixel;
	logic        in_ready;
	logic        frame_commit;
	logic        out_valid;
	disp_beat_t  out_beat;
	logic        credit_return = 1'b0;

	row_t rows [NROWS];
	int   jitter_tab [64];
	int   err_count   = 0;
	int   check_count = 0;
	bit   aborted     = 1'b0;

	// shared between stimulus, FIFO model and display monitor
	int   cur_delay   = 0;
	logic withhold    = 1'b0;
	int   stall_beats = 0;
	int   shown_seed  = 0;
	logic shown_valid = 1'b0;
	int   good_frames = 0;

	tb_clock_gen clk_gen_i (
		.clk (clk),
		.rst (rst)
	);

	frame_buffer_top #(
		.FRAME_W (FW),
		.FRAME_H (FH),
		.CREDITS (CR)
	) dut_i (
		.clk           (clk),
		.rst           (rst),
		.in_valid      (in_valid),
		.in_pixel      (in_pixel),
		.in_ready      (in_ready),
		.frame_commit  (frame_commit),
		.out_valid     (out_valid),
		.out_beat      (out_beat),
		.credit_return (credit_return)
	);

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("Error %s exp=%0h got=%0h", name, exp, got);
		end
	endtask

	// reference image colour is (x + 2y + seed) mod 8
	function automatic color_t img_color(input int x, input int y, input int seed);
		int v;
		v = (x + 2 * y + seed) % 8;
		return color_t'(v);
	endfunction

	function automatic rast_pixel_t make_pixel(input int x, input int y, input color_t c);
		rast_pixel_t p;
		p.pos.x = coord_x_t'(x);
		p.pos.y = coord_y_t'(y);
		p.color = c;
		return p;
	endfunction

	function automatic row_t make_row(input int seed, input logic [1:0] order,
			input int delay, input logic stall);
		row_t t;
		t.seed  = seed[2:0];
		t.order = order;
		t.delay = delay[1:0];
		t.stall = stall;
		return t;
	endfunction

	function automatic string order_name(input logic [1:0] order);
		if (order == ORD_FWD)
			return "forward";
		else if (order == ORD_REV)
			return "reverse";
		return "mixed";
	endfunction

	// downstream FIFO model
	// every beat is queued and its credit comes back after the row's delay plus jitter
	always @(posedge clk) begin
		int unsigned cyc;
		int beats;
		int returned;
		int ret_q [$];
		if (rst) begin
			cyc = 0;
			beats = 0;
			returned = 0;
			ret_q.delete();
			credit_return <= 1'b0;
		end else begin
			cyc++;
			// a pulse seen high here was counted by the DUT on this edge
			if (credit_return)
				returned++;
			if (out_valid) begin
				beats++;
				if (withhold)
					stall_beats++;
				ret_q.push_back(cyc + cur_delay + jitter_tab[beats % 64]);
				check_val("outstanding_le_credits", 1, (beats - returned) <= CR);
			end
			// at most one credit per cycle and none while withheld
			if (!withhold && ret_q.size() > 0 && ret_q[0] <= cyc) begin
				credit_return <= 1'b1;
				void'(ret_q.pop_front());
			end else begin
				credit_return <= 1'b0;
			end
		end
	end

	// display monitor that tracks raster position independently of the DUT
	always @(posedge clk) begin
		int pos_idx;
		int frame_seed;
		bit frame_on;
		if (rst) begin
			pos_idx = 0;
			frame_on = 1'b0;
		end else if (out_valid) begin
			check_val("out_beat.sof", pos_idx == 0, out_beat.sof);
			check_val("out_beat.eol", (pos_idx % FW) == FW - 1, out_beat.eol);
			// the image shown is fixed for the whole frame at its first pixel
			if (pos_idx == 0) begin
				frame_seed = shown_seed;
				frame_on = shown_valid;
			end
			if (frame_on)
				check_val("out_beat.color",
					img_color(pos_idx % FW, pos_idx / FW, frame_seed), out_beat.color);
			if (pos_idx == NPIX - 1) begin
				if (frame_on)
					good_frames <= good_frames + 1;
				pos_idx = 0;
			end else begin
				pos_idx++;
			end
		end
	end

	// offer one pixel and hold it until taken
	task automatic send_pixel(input rast_pixel_t p, output bit ok);
		int n;
		ok = 1'b0;
		in_valid <= 1'b1;
		in_pixel <= p;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(posedge clk);
			if (in_ready) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok)
			$display("timeout: pixel x=%0d y=%0d never accepted", p.pos.x, p.pos.y);
	endtask

	// bottom-right pixel is skipped when it was written during the previous hold
	task automatic write_image(input row_t t, input bit skip_corner, output bit ok);
		int k;
		int idx;
		int x;
		int y;
		ok = 1'b1;
		for (k = 0; k < NPIX && ok; k++) begin
			idx = (t.order == ORD_REV) ? NPIX - 1 - k : k;
			x = idx % FW;
			y = idx / FW;
			if (skip_corner && x == FW - 1 && y == FH - 1)
				continue;
			// out-of-frame pixel with the inverted colour that aliases a real address
			if (t.order == ORD_MIX) begin
				if (k % 2 == 0)
					send_pixel(make_pixel(x + FW, y, ~img_color(x, y, t.seed)), ok);
				else
					send_pixel(make_pixel(x, y + FH, ~img_color(x, y, t.seed)), ok);
			end
			if (ok)
				send_pixel(make_pixel(x, y, img_color(x, y, t.seed)), ok);
		end
	endtask

	task automatic wait_frames(input int target, output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(posedge clk);
			if (good_frames >= target) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok)
			$display("timeout: display frames stopped arriving");
	endtask

	// credits held back long enough to drain the whole credit pool
	task automatic run_stall();
		withhold <= 1'b1;
		stall_beats <= 0;
		repeat (STALL_LEN) @(posedge clk);
		withhold <= 1'b0;
		@(posedge clk);
		check_val("stall_beats_le_credits", 1, stall_beats <= CR);
	endtask

	initial begin
		int i;
		int r;
		int n;
		int err_start;
		int frames_start;
		int next_seed;
		bit ok;
		void'($urandom(32'h158b_d13a));
		for (i = 0; i < 64; i++)
			jitter_tab[i] = $urandom % 3;
		in_valid = 1'b0;
		in_pixel = '0;
		frame_commit = 1'b0;
		// consecutive seeds differ so a misplaced corner write shows up
		rows[0] = make_row(0, ORD_FWD, 0, 1'b0);
		rows[1] = make_row(3, ORD_REV, 1, 1'b0);
		rows[2] = make_row(5, ORD_MIX, 2, 1'b1);
		rows[3] = make_row(6, ORD_FWD, 3, 1'b0);
		rows[4] = make_row(1, ORD_MIX, 1, 1'b1);
		ok = 1'b0;
		for (n = 0; n < 100 && !ok; n++) begin
			@(posedge clk);
			ok = !rst;
		end
		if (!ok) begin
			$display("timeout: reset never released");
			aborted = 1'b1;
		end
		for (r = 0; r < NROWS && !aborted; r++) begin
			err_start = err_count;
			frames_start = good_frames;
			cur_delay <= rows[r].delay;
			write_image(rows[r], r > 0, ok);
			if (ok) begin
				in_valid <= 1'b0;
				frame_commit <= 1'b1;
				@(posedge clk);
				frame_commit <= 1'b0;
				// next image's corner pixel is offered during the hold and taken once ready rises
				next_seed = (r + 1 < NROWS) ? rows[r + 1].seed : rows[r].seed + 4;
				send_pixel(make_pixel(FW - 1, FH - 1,
					img_color(FW - 1, FH - 1, next_seed)), ok);
			end
			if (ok) begin
				in_valid <= 1'b0;
				shown_seed <= rows[r].seed;
				shown_valid <= 1'b1;
				if (rows[r].stall)
					run_stall();
				wait_frames(good_frames + 2, ok);
			end
			if (!ok)
				aborted = 1'b1;
			$display("row %0d seed %0d order %s delay %0d stall %0d frames %0d errors %0d",
				r, rows[r].seed, order_name(rows[r].order), rows[r].delay, rows[r].stall,
				good_frames - frames_start, err_count - err_start);
		end
		$display("rows %0d checks %0d frames %0d errors %0d aborted %0d",
			r, check_count, good_frames, err_count, aborted);
		if (err_count == 0 && !aborted)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* flist.f */
rtl/fb_geom_pkg.sv
rtl/fb_stream_pkg.sv
rtl/frame_cell.sv
rtl/pixel_writer.sv
rtl/scan_reader.sv
rtl/frame_buffer_ctrl.sv
rtl/frame_buffer_top.sv
tb/tb_clock_gen.sv
tb/frame_buffer_tb.sv
